// File: compile.f
verilog/mempool_pkg.sv
verilog/addr_decoder.sv
verilog/l2_mem.sv
verilog/bootrom.sv
verilog/ctrl_registers.sv
verilog/rsp_mux.sv
verilog/mempool_system.sv
dv/mempool_system_checker.sv
dv/tb_mempool_system.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mempool_system
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_mempool_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory system. Keeps shadow copies of L2 and eoc,
// and checks every response and the side outputs in each cycle.
// L2 is filled before it is read, power-up contents are not modeled.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_mempool_system;

  import mempool_pkg::*;

  typedef struct packed {
    bus_rsp_t            rsp;
    logic [NumCores-1:0] wake;
    logic                eoc_valid;
  } expect_t;

  localparam int ClkPeriod      = 40;
  localparam int MixLength      = 200;
  localparam int NumRequests    = 2 * L2NumWords + 64 + 27 + 8 + 7 + 4 + 4 + MixLength + 2;
  localparam int WatchdogCycles = NumRequests + 100;  // Margin for reset and drains

  logic                clk_i   = 1'b0;
  logic                reset_i = 1'b1;
  bus_req_t            req_i   = '0;
  bus_rsp_t            rsp_o;
  logic [NumCores-1:0] wake_up_o;
  logic                eoc_valid_o;

  data_t       l2_shadow [L2NumWords];
  data_t       eoc_shadow = '0;
  logic [31:0] lcg_state  = 32'h1698;
  expect_t     exp_q [$];
  expect_t     cur_exp;
  logic        eoc_exp    = 1'b0;  // eoc_valid_o after the last answered request
  logic        was_valid  = 1'b0;
  int          errors     = 0;
  int          fails      = 0;
  int          num_tests  = 0;

  mempool_system dut0 (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_i       (req_i      ),
    .rsp_o       (rsp_o      ),
    .wake_up_o   (wake_up_o  ),
    .eoc_valid_o (eoc_valid_o)
  );

  bind mempool_system mempool_system_checker i_checker (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_i       (req_i      ),
    .rsp_i       (rsp_o      ),
    .wake_up_i   (wake_up_o  ),
    .eoc_valid_i (eoc_valid_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Every address bit reaches the fill word
  function automatic data_t fill_word(input addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_1698;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t be);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // Expected response and side outputs, updates the shadow state
  function automatic expect_t ref_model(input bus_req_t req);
    expect_t                 e;
    logic [15:0]             offs;
    logic [L2AddrWidth-1:0]  l2_idx;
    logic [BootIdxWidth-1:0] boot_idx;
    e           = '0;
    e.rsp.valid = 1'b1;
    offs        = req.addr[15:0];
    if (req.addr[31:16] == CtrlBaseAddr[31:16]) begin
      if (offs == CtrlEocOffs && req.we) begin
        eoc_shadow = merge_bytes(eoc_shadow, req.wdata, req.be);
      end else if (offs == CtrlEocOffs) begin
        e.rsp.rdata = eoc_shadow;
      end else if (offs == CtrlWakeOffs) begin
        e.wake = req.we ? req.wdata[NumCores-1:0] : '0;  // Reads return 0
      end else if (offs == CtrlL2StartOffs || offs == CtrlL2EndOffs
                   || offs == CtrlNumCoresOffs) begin
        e.rsp.err = req.we;  // Read-only information
        if (!req.we && offs == CtrlL2StartOffs) e.rsp.rdata = L2BaseAddr;
        if (!req.we && offs == CtrlL2EndOffs) e.rsp.rdata = L2BaseAddr + L2Size - 1;
        if (!req.we && offs == CtrlNumCoresOffs) e.rsp.rdata = NumCores;
      end else begin
        e.rsp.err = 1'b1;
      end
    end else if (req.addr - L2BaseAddr < L2Size) begin
      l2_idx = L2AddrWidth'((req.addr - L2BaseAddr) >> 2);
      if (req.we) l2_shadow[l2_idx] = merge_bytes(l2_shadow[l2_idx], req.wdata, req.be);
      else e.rsp.rdata = l2_shadow[l2_idx];
    end else if (req.addr[31:16] == BootBaseAddr[31:16]) begin
      boot_idx    = BootIdxWidth'(req.addr >> 2);  // Image repeats over the window
      e.rsp.err   = req.we;
      e.rsp.rdata = req.we ? '0 : BootImage[boot_idx];
    end else begin
      e.rsp.err = 1'b1;  // Decode error
    end
    e.eoc_valid = eoc_shadow[0];
    return e;
  endfunction

  task automatic compare_rsp(input bus_rsp_t got, input bus_rsp_t exp);
    // Idle cycles only promise a low valid
    if (got !== exp && (exp.valid || got.valid)) begin
      $display("Error: rsp_o got %h expected %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic compare_wake(input logic [NumCores-1:0] got,
                              input logic [NumCores-1:0] exp);
    if (got !== exp) begin
      $display("Error: wake_up_o got %h expected %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: eoc_valid_o got %h expected %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic send(input logic we, input addr_t addr, input data_t wdata, input strb_t be);
    bus_req_t req;
    req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
    @(posedge clk_i);
    req_i <= req;
    exp_q.push_back(ref_model(req));
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      req_i <= '0;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    idle(3);  // Last response drains
    if (exp_q.size() != 0) begin
      $display("Test %s left %0d responses unchecked", name, exp_q.size());
      errors++;
    end
    num_tests++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      fails++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    cur_exp = '0;
    if (was_valid) begin
      cur_exp = exp_q.pop_front();
      eoc_exp = cur_exp.eoc_valid;
    end
    compare_rsp(rsp_o, cur_exp.rsp);
    compare_wake(wake_up_o, cur_exp.wake);
    compare_flag(eoc_valid_o, eoc_exp);
    was_valid = req_i.valid && !reset_i;
    if (reset_i) eoc_exp = 1'b0;  // Cleared at the next rising edge
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired, the run did not end within %0d cycles", WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int          start;
    logic [31:0] r;
    addr_t       a;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    start = errors;
    for (int i = 0; i < L2NumWords; i++) begin
      send(1'b1, L2BaseAddr + 4 * i, fill_word(L2BaseAddr + 4 * i), 4'hF);
    end
    for (int i = 0; i < 64; i++) begin
      r = lcg_next();
      send(1'b1, L2BaseAddr + {22'd0, r[25:16]}, lcg_next(), r[31:28]);
    end
    for (int i = 0; i < L2NumWords; i++) begin
      send(1'b0, L2BaseAddr + 4 * i, '0, 4'hF);
    end
    finish_test("l2_byte_writes", start);

    start = errors;
    for (int i = 0; i < 24; i++) begin
      send(1'b0, BootBaseAddr + 4 * i, '0, 4'hF);  // Wraps past 16 words
    end
    send(1'b1, BootBaseAddr + 32'h8, 32'h1234_5678, 4'hF);
    send(1'b0, BootBaseAddr + 32'h8, '0, 4'hF);
    send(1'b0, BootBaseAddr + 32'hFFFC, '0, 4'hF);
    finish_test("boot_rom", start);

    start = errors;
    send(1'b0, CtrlBaseAddr + CtrlL2StartOffs, '0, 4'hF);
    send(1'b0, CtrlBaseAddr + CtrlL2EndOffs, '0, 4'hF);
    send(1'b0, CtrlBaseAddr + CtrlNumCoresOffs, '0, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlL2StartOffs, 32'hFFFF_FFFF, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlL2EndOffs, 32'h0, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlNumCoresOffs, 32'h20, 4'hF);
    send(1'b0, CtrlBaseAddr + 32'h14, '0, 4'hF);
    send(1'b1, CtrlBaseAddr + 32'hFFFC, 32'hFFFF_FFFF, 4'hF);
    finish_test("ctrl_registers", start);

    start = errors;
    send(1'b0, CtrlBaseAddr + CtrlEocOffs, '0, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlEocOffs, 32'h0000_1230, 4'hF);
    send(1'b0, CtrlBaseAddr + CtrlEocOffs, '0, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlEocOffs, 32'hCAFE_0001, 4'hF);
    idle(2);
    send(1'b0, CtrlBaseAddr + CtrlEocOffs, '0, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlEocOffs, 32'hFFFF_FF00, 4'h1);  // Byte 0 only
    send(1'b0, CtrlBaseAddr + CtrlEocOffs, '0, 4'hF);
    finish_test("end_of_computation", start);

    start = errors;
    send(1'b1, CtrlBaseAddr + CtrlWakeOffs, 32'h1234_56A5, 4'hF);
    idle(2);
    send(1'b0, CtrlBaseAddr + CtrlWakeOffs, '0, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlWakeOffs, 32'h0000_003C, 4'hF);
    send(1'b1, CtrlBaseAddr + CtrlWakeOffs, 32'h0000_00FF, 4'hF);
    finish_test("wake_up", start);

    start = errors;
    send(1'b0, 32'h0000_0000, '0, 4'hF);
    send(1'b0, L2BaseAddr + L2Size, '0, 4'hF);  // First byte past L2
    send(1'b1, 32'h3FFF_FFFC, 32'h5555_AAAA, 4'hF);
    send(1'b0, BootBaseAddr + 32'h0001_0000, '0, 4'hF);
    for (int i = 0; i < MixLength; i++) begin
      r = lcg_next();
      case (r[31:30])
        2'd0:    a = CtrlBaseAddr + {27'd0, r[20:18], 2'b00};
        2'd1:    a = L2BaseAddr + {22'd0, r[25:16]};
        2'd2:    a = BootBaseAddr + {16'd0, r[15:0]};
        default: a = 32'h6000_0000 | (r & 32'h0FFF_FFFC);  // Unmapped
      endcase
      send(r[29], a, lcg_next(), r[27:24]);
    end
    finish_test("decode_and_mix", start);

    // eoc set, then a reset in mid-run must clear it
    start = errors;
    send(1'b1, CtrlBaseAddr + CtrlEocOffs, 32'h0000_0001, 4'hF);
    idle(2);
    reset_i    <= 1'b1;
    eoc_shadow  = '0;
    idle(4);
    reset_i <= 1'b0;
    send(1'b0, CtrlBaseAddr + CtrlEocOffs, '0, 4'hF);
    finish_test("reset_clears_eoc", start);

    $display("Summary: %0d tests, %0d failed, %0d errors", num_tests, fails, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_mempool_system

// File: dv/mempool_system_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Port assertions for the memory system, bound to its top level.
// Assumes one request per cycle at most and no back-pressure.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mempool_system_checker (
  input logic                             clk_i,
  input logic                             reset_i,
  input mempool_pkg::bus_req_t            req_i,
  input mempool_pkg::bus_rsp_t            rsp_i,
  input logic [mempool_pkg::NumCores-1:0] wake_up_i,
  input logic                             eoc_valid_i
);

  // Exactly one response, one cycle after each request
  rsp_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_i.valid == $past(req_i.valid))
    else $error("rsp_o.valid is not req_i.valid delayed by one cycle");

  wake_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(req_i.valid) |-> wake_up_i == '0)
    else $error("wake_up_o active without a request in the previous cycle");

  err_has_zero_data: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_i.valid && rsp_i.err |-> rsp_i.rdata == '0)
    else $error("Error response carries nonzero rdata");

  // Synchronous reset, so eoc is cleared from the cycle after reset is seen
  eoc_low_in_reset: assert property (@(posedge clk_i)
    reset_i |=> !eoc_valid_i)
    else $error("eoc_valid_o high during reset");

endmodule : mempool_system_checker

// File: verilog/mempool_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory system top: decoder, L2, boot ROM, control registers and
// response combiner. Every request is answered exactly one cycle later.
// The core cluster is not included, only its wake-up strobe leaves here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mempool_system (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  mempool_pkg::bus_req_t            req_i,
  output mempool_pkg::bus_rsp_t            rsp_o,
  output logic [mempool_pkg::NumCores-1:0] wake_up_o,
  output logic                             eoc_valid_o
);

  import mempool_pkg::*;

  logic     ctrl_sel;
  logic     l2_sel;
  logic     boot_sel;
  region_e  region_q;
  bus_rsp_t ctrl_rsp;
  bus_rsp_t l2_rsp;
  bus_rsp_t boot_rsp;

  addr_decoder i_addr_decoder (
    .clk_i      (clk_i   ),
    .reset_i    (reset_i ),
    .req_i      (req_i   ),
    .ctrl_sel_o (ctrl_sel),
    .l2_sel_o   (l2_sel  ),
    .boot_sel_o (boot_sel),
    .region_q_o (region_q)
  );

  l2_mem i_l2_mem (
    .clk_i (clk_i ),
    .sel_i (l2_sel),
    .req_i (req_i ),
    .rsp_o (l2_rsp)
  );

  bootrom i_bootrom (
    .clk_i (clk_i   ),
    .sel_i (boot_sel),
    .req_i (req_i   ),
    .rsp_o (boot_rsp)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .sel_i       (ctrl_sel   ),
    .req_i       (req_i      ),
    .rsp_o       (ctrl_rsp   ),
    .wake_up_o   (wake_up_o  ),
    .eoc_valid_o (eoc_valid_o)
  );

  rsp_mux i_rsp_mux (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_valid_i (req_i.valid),  // Tracks pending requests for decode errors
    .region_q_i  (region_q   ),
    .ctrl_rsp_i  (ctrl_rsp   ),
    .l2_rsp_i    (l2_rsp     ),
    .boot_rsp_i  (boot_rsp   ),
    .rsp_o       (rsp_o      )
  );

endmodule : mempool_system

// File: verilog/rsp_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response combiner. Forwards the target picked by the previous
// cycle's region, or a decode error for a pending unmapped request.
// Needs the request valid to tell idle cycles from decode errors.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rsp_mux (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  input  mempool_pkg::region_e  region_q_i,
  input  mempool_pkg::bus_rsp_t ctrl_rsp_i,
  input  mempool_pkg::bus_rsp_t l2_rsp_i,
  input  mempool_pkg::bus_rsp_t boot_rsp_i,
  output mempool_pkg::bus_rsp_t rsp_o
);

  import mempool_pkg::*;

  logic pending_q;  // A request was strobed last cycle

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= req_valid_i;
    end
  end

  always_comb begin
    case (region_q_i)
      RegionCtrl: rsp_o = ctrl_rsp_i;
      RegionL2:   rsp_o = l2_rsp_i;
      RegionBoot: rsp_o = boot_rsp_i;
      default: begin
        rsp_o.valid = pending_q;
        rsp_o.err   = pending_q;  // Decode error
        rsp_o.rdata = '0;
      end
    endcase
  end

endmodule : rsp_mux

// File: verilog/ctrl_registers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control registers: end-of-computation word, core wake-up strobe and
// read-only system information. Decoded on the low 16 address bits.
// The wake-up output is a one-cycle pulse, reads of it return zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ctrl_registers (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             sel_i,
  input  mempool_pkg::bus_req_t            req_i,
  output mempool_pkg::bus_rsp_t            rsp_o,
  output logic [mempool_pkg::NumCores-1:0] wake_up_o,
  output logic                             eoc_valid_o
);

  import mempool_pkg::*;

  logic [15:0]         offs;
  logic                wr_eoc;
  logic                wr_wake;
  data_t               eoc_q;
  logic [NumCores-1:0] wake_q;
  bus_rsp_t            rsp_d;
  bus_rsp_t            rsp_q;

  assign offs    = req_i.addr[15:0];
  assign wr_eoc  = sel_i && req_i.we && (offs == CtrlEocOffs);
  assign wr_wake = sel_i && req_i.we && (offs == CtrlWakeOffs);

  // Response for the current request, registered below
  always_comb begin
    rsp_d       = '0;
    rsp_d.valid = sel_i;
    case (offs)
      CtrlEocOffs: begin
        if (!req_i.we) rsp_d.rdata = eoc_q;
      end
      CtrlWakeOffs: begin
        rsp_d.rdata = '0;  // Write-only strobe
      end
      CtrlL2StartOffs: begin
        rsp_d.err   = req_i.we;
        rsp_d.rdata = req_i.we ? '0 : L2BaseAddr;
      end
      CtrlL2EndOffs: begin
        rsp_d.err   = req_i.we;
        rsp_d.rdata = req_i.we ? '0 : L2BaseAddr + L2Size - 1;
      end
      CtrlNumCoresOffs: begin
        rsp_d.err   = req_i.we;
        rsp_d.rdata = req_i.we ? '0 : data_t'(NumCores);
      end
      default: begin
        rsp_d.err = 1'b1;  // Unknown offset
      end
    endcase
    if (!sel_i) begin
      rsp_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q  <= '0;
      wake_q <= '0;
      rsp_q  <= '0;
    end else begin
      wake_q <= '0;  // Pulse lasts one cycle
      if (wr_eoc) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (req_i.be[b]) eoc_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      if (wr_wake) begin
        wake_q <= req_i.wdata[NumCores-1:0];  // One bit per core
      end
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o       = rsp_q;
  assign wake_up_o   = wake_q;
  assign eoc_valid_o = eoc_q[0];  // Bit 0 flags the end of computation

endmodule : ctrl_registers

// File: verilog/bootrom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot ROM. The image repeats every BootNumWords words over the window.
// Writes are dropped and answered with an error.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module bootrom (
  input  logic                  clk_i,
  input  logic                  sel_i,
  input  mempool_pkg::bus_req_t req_i,
  output mempool_pkg::bus_rsp_t rsp_o
);

  import mempool_pkg::*;

  logic [BootIdxWidth-1:0] rom_idx;
  logic                    valid_q;
  logic                    err_q;
  data_t                   rdata_q;

  // Truncation gives the index modulo the image size
  assign rom_idx = req_i.addr[ByteOffset +: BootIdxWidth];

  always_ff @(posedge clk_i) begin
    valid_q <= sel_i;
    if (sel_i) begin
      err_q   <= req_i.we;
      rdata_q <= req_i.we ? '0 : BootImage[rom_idx];
    end
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.err   = err_q;
  assign rsp_o.rdata = rdata_q;

endmodule : bootrom

// File: verilog/l2_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 memory, single port, one word wide, byte-enabled writes.
// Read data arrives one cycle after the select strobe.
// Contents are undefined after power-up, upper address bits are ignored.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module l2_mem (
  input  logic                  clk_i,
  input  logic                  sel_i,
  input  mempool_pkg::bus_req_t req_i,
  output mempool_pkg::bus_rsp_t rsp_o
);

  import mempool_pkg::*;

  data_t                  mem_q [L2NumWords];
  logic [L2AddrWidth-1:0] word_idx;
  data_t                  rdata_q;
  logic                   valid_q;

  assign word_idx = req_i.addr[ByteOffset +: L2AddrWidth];  // Word inside the window

  // Storage with per-byte write enables
  always_ff @(posedge clk_i) begin
    if (sel_i && req_i.we) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (req_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read port, writes answer with zero data
  always_ff @(posedge clk_i) begin
    valid_q <= sel_i;
    if (sel_i) begin
      rdata_q <= req_i.we ? '0 : mem_q[word_idx];
    end
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.err   = 1'b0;  // Every access inside the window is legal
  assign rsp_o.rdata = rdata_q;

endmodule : l2_mem

// File: verilog/addr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder. Selects are combinational from the request,
// region_q_o holds the region of the previous cycle's address.
// Windows are half-open ranges taken from the package memory map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module addr_decoder (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mempool_pkg::bus_req_t req_i,
  output logic                  ctrl_sel_o,
  output logic                  l2_sel_o,
  output logic                  boot_sel_o,
  output mempool_pkg::region_e  region_q_o
);

  import mempool_pkg::*;

  region_e region_d;

  always_comb begin
    region_d = RegionNone;
    if (req_i.addr >= CtrlBaseAddr && req_i.addr < CtrlBaseAddr + CtrlSize) begin
      region_d = RegionCtrl;
    end else if (req_i.addr >= L2BaseAddr && req_i.addr < L2BaseAddr + L2Size) begin
      region_d = RegionL2;
    end else if (req_i.addr >= BootBaseAddr && req_i.addr < BootBaseAddr + BootSize) begin
      region_d = RegionBoot;
    end
  end

  // One strobe per target, only for a live request
  assign ctrl_sel_o = req_i.valid && (region_d == RegionCtrl);
  assign l2_sel_o   = req_i.valid && (region_d == RegionL2);
  assign boot_sel_o = req_i.valid && (region_d == RegionBoot);

  // Remembered for the response cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      region_q_o <= RegionNone;
    end else begin
      region_q_o <= region_d;
    end
  end

endmodule : addr_decoder

// File: verilog/mempool_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared bus types, memory map and boot image of the memory system.
// Single 32-bit word bus, one request per cycle, no back-pressure.
// Region windows must stay aligned to their own size.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mempool_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    RegionCtrl,
    RegionL2,
    RegionBoot,
    RegionNone  // Unmapped address
  } region_e;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t be;
  } bus_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  localparam int unsigned NumCores   = 8;   // Width of the wake-up strobe
  localparam int unsigned ByteOffset = 2;   // Byte bits below the word index

  // Memory map
  localparam addr_t       CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t       CtrlSize     = 32'h0001_0000;
  localparam addr_t       L2BaseAddr   = 32'h8000_0000;
  localparam addr_t       L2Size       = 32'd1024;
  localparam int unsigned L2NumWords   = L2Size / 4;
  localparam int unsigned L2AddrWidth  = $clog2(L2NumWords);
  localparam addr_t       BootBaseAddr = 32'hA000_0000;
  localparam addr_t       BootSize     = 32'h0001_0000;
  localparam int unsigned BootNumWords = 16;
  localparam int unsigned BootIdxWidth = $clog2(BootNumWords);

  // Control register offsets inside the control window
  localparam logic [15:0] CtrlEocOffs      = 16'h0000;
  localparam logic [15:0] CtrlWakeOffs     = 16'h0004;
  localparam logic [15:0] CtrlL2StartOffs  = 16'h0008;
  localparam logic [15:0] CtrlL2EndOffs    = 16'h000C;
  localparam logic [15:0] CtrlNumCoresOffs = 16'h0010;

  // Boot code: set up a stack in L2, signal end of computation, then sleep
  localparam data_t BootImage [BootNumWords] = '{
    32'h8000_0137, 32'h4001_0113, 32'h4000_02B7, 32'h0010_0313,
    32'h0062_A023, 32'h1050_0073, 32'hFFDF_F06F, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'hDEAD_BEEF, 32'hC0FF_EE00, 32'h0000_0000, 32'hFFFF_FFFF
  };

endpackage : mempool_pkg
